/* sim.f */
common/mipsPkg.sv
logic/alu.sv
datapath/regFile.sv
datapath/mipsDatapath.sv
controller/aluDecoder.sv
controller/mipsController.sv
logic/mipsCore.sv
tb/mipsCoreTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing
TOP      = mipsCoreTb
FILELIST = sim.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASSMSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* tb/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int dataWidth = 32;
	localparam int addrWidth = 10;
	localparam int memWords = 1 << addrWidth;
	localparam int resetCycles = 8;
	localparam int storeWaitCycles = 50;
	localparam int numRows = 24;
	// Rows x 12 instructions x 6 cycles x 4 ns plus reset time per row
	localparam int watchdogNs = numRows * 12 * 6 * 4 + numRows * 12 * 4 + 400;
	// Byte 0x440
	localparam logic [addrWidth-1:0] resultWord = 10'h110;

	// Opcodes of the program skeleton
	localparam logic [5:0] opcAddi = 6'b001000;
	localparam logic [5:0] opcLw   = 6'b100011;
	localparam logic [5:0] opcSw   = 6'b101011;
	localparam logic [5:0] opcBeq  = 6'b000100;
	localparam logic [5:0] opcJ    = 6'b000010;

	typedef enum int {
		opAdd, opSub, opAnd, opOr, opXor, opSlt, opSll, opSrl, opSra,
		opAddi, opSlti, opAndi, opOri, opXori, opMem, opBeq, opJ, opZero
	} testOpT;

	// Stimulus row where rnd swaps in LCG operands
	typedef struct packed {
		testOpT      op;
		logic [31:0] a;
		logic [31:0] b;
		bit          rnd;
	} rowT;

	logic                 clk;
	logic                 rst;
	logic [addrWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWdata;
	logic                 memWe;
	logic [dataWidth-1:0] memRdata;

	logic [31:0] mem [memWords];
	logic [31:0] image [memWords];
	rowT         rowTable [numRows];
	logic [31:0] rngState;
	int          errCount;
	int          passCount;
	int          failCount;

	mipsCore #(.dataWidth(dataWidth), .addrWidth(addrWidth)) mipsCore_inst (
		.clk     (clk),
		.rst     (rst),
		.memAddr (memAddr),
		.memWdata(memWdata),
		.memWe   (memWe),
		.memRdata(memRdata)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////
	// Memory model
	//////////////////////////////

	// Reset reloads the program image
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i] <= image[i];
			end
		end else if (memWe) begin
			mem[memAddr] <= memWdata;
		end
		// Word shows up one clock after its address
		memRdata <= mem[memAddr];
	end

	// No store may leave the core while it sits in reset
	always @(negedge clk) begin
		if (rst && memWe === 1'b1) begin
			$display("** Error at %0t: memWe high during reset", $time);
			errCount++;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lcgNext();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	// Background word unique to each address
	function automatic logic [31:0] fillWord(input int idx);
		return 32'h5A000000 | (32'(idx) << 12) | 32'(idx);
	endfunction

	function automatic logic [31:0] rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'b000000, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iTypeWord(input logic [5:0] opc, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jumpWord(input logic [25:0] target);
		return {opcJ, target};
	endfunction

	// sw rt, -0x20(r5) lands on byte 0x440
	function automatic logic [31:0] storeToResult(input logic [4:0] rt);
		return iTypeWord(opcSw, 5'd5, rt, 16'hFFE0);
	endfunction

	// MIPS result rules for each row kind
	function automatic logic [31:0] expectedResult(input testOpT op, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] immSext;
		logic [31:0] immZext;
		immSext = {{16{b[15]}}, b[15:0]};
		immZext = {16'h0000, b[15:0]};
		case (op)
			opAdd:   return a + b;
			opSub:   return a - b;
			opAnd:   return a & b;
			opOr:    return a | b;
			opXor:   return a ^ b;
			opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			// Shift amount from a and value from b
			opSll:   return b << a[4:0];
			opSrl:   return b >> a[4:0];
			opSra:   return $signed(b) >>> a[4:0];
			opAddi:  return a + immSext;
			opSlti:  return ($signed(a) < $signed(immSext)) ? 32'd1 : 32'd0;
			opAndi:  return a & immZext;
			opOri:   return a | immZext;
			opXori:  return a ^ immZext;
			opMem:   return fillWord('h11C);
			// Taken branch skips the marker store
			opBeq:   return (a == b) ? a : 32'h00007777;
			opJ:     return b;
			default: return 32'd0;
		endcase
	endfunction

	task automatic buildProgram(input testOpT op, input logic [31:0] a, input logic [31:0] b);
		for (int i = 0; i < memWords; i++) begin
			image[i] = fillWord(i);
		end
		image['h100] = a;
		image['h101] = b;
		// r5 = 0x460 so negative offsets reach the operands at 0x400 and 0x404
		image[0] = iTypeWord(opcAddi, 5'd0, 5'd5, 16'h0460);
		image[1] = iTypeWord(opcLw, 5'd5, 5'd1, 16'hFFA0);
		image[2] = iTypeWord(opcLw, 5'd5, 5'd2, 16'hFFA4);
		image[4] = storeToResult(5'd3);
		image[5] = jumpWord(26'd5);
		case (op)
			opAdd:  image[3] = rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, 6'b100000);
			opSub:  image[3] = rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, 6'b100010);
			opAnd:  image[3] = rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, 6'b100100);
			opOr:   image[3] = rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, 6'b100101);
			opXor:  image[3] = rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, 6'b100110);
			opSlt:  image[3] = rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, 6'b101010);
			opSll:  image[3] = rTypeWord(5'd0, 5'd2, 5'd3, a[4:0], 6'b000000);
			opSrl:  image[3] = rTypeWord(5'd0, 5'd2, 5'd3, a[4:0], 6'b000010);
			opSra:  image[3] = rTypeWord(5'd0, 5'd2, 5'd3, a[4:0], 6'b000011);
			opAddi: image[3] = iTypeWord(opcAddi, 5'd1, 5'd3, b[15:0]);
			opSlti: image[3] = iTypeWord(6'b001010, 5'd1, 5'd3, b[15:0]);
			opAndi: image[3] = iTypeWord(6'b001100, 5'd1, 5'd3, b[15:0]);
			opOri:  image[3] = iTypeWord(6'b001101, 5'd1, 5'd3, b[15:0]);
			opXori: image[3] = iTypeWord(6'b001110, 5'd1, 5'd3, b[15:0]);
			opMem: begin
				// Positive offsets load from 0x470 and store to 0x440
				image[3] = iTypeWord(opcAddi, 5'd0, 5'd6, 16'h0400);
				image[4] = iTypeWord(opcLw, 5'd6, 5'd3, 16'h0070);
				image[5] = iTypeWord(opcSw, 5'd6, 5'd3, 16'h0040);
				image[6] = jumpWord(26'd6);
			end
			opBeq: begin
				image[3] = iTypeWord(opcAddi, 5'd0, 5'd3, 16'h7777);
				// Target is word 6
				image[4] = iTypeWord(opcBeq, 5'd1, 5'd2, 16'h0001);
				image[5] = storeToResult(5'd3);
				image[6] = storeToResult(5'd1);
				image[7] = jumpWord(26'd7);
			end
			opJ: begin
				image[3] = jumpWord(26'd5);
				image[4] = storeToResult(5'd1);
				image[5] = storeToResult(5'd2);
				image[6] = jumpWord(26'd6);
			end
			opZero: begin
				// Add into r0 and store r0 afterwards
				image[3] = rTypeWord(5'd1, 5'd2, 5'd0, 5'd0, 6'b100000);
				image[4] = storeToResult(5'd0);
			end
		endcase
	endtask

	task automatic fillTable();
		rowTable[0]  = '{opAdd,  32'd5,        32'd7,        1'b0};
		rowTable[1]  = '{opAdd,  32'h7FFFFFFF, 32'd1,        1'b0};
		rowTable[2]  = '{opSub,  32'd3,        32'd10,       1'b0};
		rowTable[3]  = '{opAnd,  32'd0,        32'd0,        1'b1};
		rowTable[4]  = '{opOr,   32'd0,        32'd0,        1'b1};
		rowTable[5]  = '{opXor,  32'd0,        32'd0,        1'b1};
		rowTable[6]  = '{opSlt,  32'hFFFFFFFB, 32'd3,        1'b0};
		rowTable[7]  = '{opSlt,  32'd3,        32'hFFFFFFFB, 1'b0};
		rowTable[8]  = '{opSlt,  32'hFFFFFFF9, 32'hFFFFFFFE, 1'b0};
		rowTable[9]  = '{opSll,  32'd4,        32'd1,        1'b0};
		rowTable[10] = '{opSll,  32'd0,        32'd0,        1'b1};
		rowTable[11] = '{opSrl,  32'd8,        32'h80000000, 1'b0};
		rowTable[12] = '{opSra,  32'd4,        32'h80000000, 1'b0};
		rowTable[13] = '{opSra,  32'd0,        32'd0,        1'b1};
		rowTable[14] = '{opAddi, 32'd10,       32'h0000FFF0, 1'b0};
		rowTable[15] = '{opSlti, 32'hFFFFFFFB, 32'h0000FFF6, 1'b0};
		rowTable[16] = '{opAndi, 32'hFFFFFFFF, 32'h00008001, 1'b0};
		rowTable[17] = '{opOri,  32'h12340000, 32'h00008000, 1'b0};
		rowTable[18] = '{opXori, 32'd0,        32'd0,        1'b1};
		rowTable[19] = '{opMem,  32'd0,        32'd0,        1'b0};
		rowTable[20] = '{opBeq,  32'd5,        32'd5,        1'b0};
		rowTable[21] = '{opBeq,  32'd5,        32'd6,        1'b0};
		rowTable[22] = '{opJ,    32'd11,       32'd22,       1'b0};
		rowTable[23] = '{opZero, 32'd3,        32'd4,        1'b0};
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		testOpT      op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expected;
		logic [31:0] got;
		bit          stored;
		int          cycles;
		int          changed;
		int          errBefore;

		$timeformat(-9, 1, " ns", 0);
		clk = 1'b0;
		rst = 1'b1;
		memRdata = '0;
		rngState = 32'd18;
		errCount = 0;
		passCount = 0;
		failCount = 0;
		got = '0;
		fillTable();
		for (int r = 0; r < numRows; r++) begin
			errBefore = errCount;
			op = rowTable[r].op;
			a = rowTable[r].a;
			b = rowTable[r].b;
			if (rowTable[r].rnd) begin
				a = lcgNext();
				b = lcgNext();
			end
			expected = expectedResult(op, a, b);
			buildProgram(op, a, b);
			// Hold the core in reset while memory takes the image
			@(posedge clk);
			rst <= 1'b1;
			repeat (resetCycles) @(posedge clk);
			rst <= 1'b0;
			@(negedge clk);
			if (memAddr !== '0) begin
				$display("** Error at %0t: first fetch address %h, not zero", $time, memAddr);
				errCount++;
			end
			// Wait for the first store to the result word
			stored = 1'b0;
			cycles = 0;
			while (!stored && cycles < storeWaitCycles) begin
				if (memWe === 1'b1 && memAddr === resultWord) begin
					stored = 1'b1;
					got = memWdata;
				end else begin
					@(negedge clk);
					cycles++;
				end
			end
			if (!stored) begin
				$display("Row %0d: no store to the result address happened", r);
				errCount++;
			end else if (got !== expected) begin
				$display("** Error at %0t: row %0d %s stored %h, expected %h",
					$time, r, op.name(), got, expected);
				errCount++;
			end
			// Rest of memory must match the image once the store lands
			repeat (2) @(negedge clk);
			changed = 0;
			for (int i = 0; i < memWords; i++) begin
				if (addrWidth'(i) != resultWord && mem[i] !== image[i]) begin
					changed++;
				end
			end
			if (changed != 0) begin
				$display("** Error at %0t: row %0d changed %0d words outside the result",
					$time, r, changed);
				errCount++;
			end
			if (errCount == errBefore) begin
				passCount++;
				$display("Row %0d %s a=%h b=%h: ok", r, op.name(), a, b);
			end else begin
				failCount++;
				$display("Row %0d %s a=%h b=%h: bad", r, op.name(), a, b);
			end
		end
		$display("Rows %0d, good %0d, bad %0d, errors %0d", numRows, passCount, failCount,
			errCount);
		if (errCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Hang guard
	initial begin
		#(watchdogNs);
		$display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore
	import mipsPkg::*;
#(
	parameter int dataWidth = 32,
	parameter int addrWidth = 10
) (
	input  logic                 clk,
	input  logic                 rst,
	output logic [addrWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWdata,
	output logic                 memWe,
	input  logic [dataWidth-1:0] memRdata
);

	logic    iorD;
	srcAT    srcA;
	srcBT    srcB;
	pcSrcT   pcSrc;
	logic    irWrite;
	logic    pcWrite;
	logic    branch;
	logic    regWrite;
	logic    regDst;
	logic    memToReg;
	aluCtrlT aluCtrl;
	opcodeT  opcode;
	functT   funct;

	mipsController mipsController_inst (
		.clk(clk), .rst(rst), .opcode(opcode), .funct(funct),
		.iorD(iorD), .srcA(srcA), .srcB(srcB), .pcSrc(pcSrc),
		.irWrite(irWrite), .pcWrite(pcWrite), .branch(branch),
		.regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
		.memWe(memWe), .aluCtrl(aluCtrl)
	);

	mipsDatapath #(.dataWidth(dataWidth), .addrWidth(addrWidth)) mipsDatapath_inst (
		.clk(clk), .rst(rst), .iorD(iorD), .srcA(srcA), .srcB(srcB),
		.pcSrc(pcSrc), .irWrite(irWrite), .pcWrite(pcWrite), .branch(branch),
		.regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
		.aluCtrl(aluCtrl), .memRdata(memRdata), .opcode(opcode), .funct(funct),
		.memAddr(memAddr), .memWdata(memWdata)
	);

endmodule

/* controller/mipsController.sv */
`timescale 1ns/1ps

module mipsController
	import mipsPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  opcodeT  opcode,
	input  functT   funct,
	output logic    iorD,
	output srcAT    srcA,
	output srcBT    srcB,
	output pcSrcT   pcSrc,
	output logic    irWrite,
	output logic    pcWrite,
	output logic    branch,
	output logic    regWrite,
	output logic    regDst,
	output logic    memToReg,
	output logic    memWe,
	output aluCtrlT aluCtrl
);

	ctrlStateT state;
	ctrlStateT stateNext;
	aluOpT     aluOp;
	aluOpT     aluOpNext;
	logic      iorDNext;
	srcAT      srcANext;
	srcBT      srcBNext;
	pcSrcT     pcSrcNext;
	logic      irWriteNext;
	logic      pcWriteNext;
	logic      branchNext;
	logic      regWriteNext;
	logic      regDstNext;
	logic      memToRegNext;
	logic      memWeNext;
	logic      isShift;

	// Shift amount comes from the shamt field, not rs
	assign isShift = (funct == functSll) || (funct == functSrl) || (funct == functSra);

	aluDecoder aluDecoder_inst (
		.aluOp  (aluOp),
		.funct  (funct),
		.opcode (opcode),
		.aluCtrl(aluCtrl)
	);

	//////////////////////////////
	// Next state and controls
	//////////////////////////////

	// Controls decided here take effect in the following cycle
	always_comb begin
		stateNext    = fetchAddr;
		iorDNext     = 1'b0;
		srcANext     = pc;
		srcBNext     = four;
		pcSrcNext    = aluResult;
		aluOpNext    = addOp;
		irWriteNext  = 1'b0;
		pcWriteNext  = 1'b0;
		branchNext   = 1'b0;
		regWriteNext = 1'b0;
		regDstNext   = 1'b0;
		memToRegNext = 1'b0;
		memWeNext    = 1'b0;
		case (state)
			fetchAddr: begin
				// Latch instruction and step PC by four
				stateNext   = fetchLatch;
				irWriteNext = 1'b1;
				pcWriteNext = 1'b1;
			end
			fetchLatch: begin
				// Branch target into ALU result register
				stateNext = decode;
				srcBNext  = signImm;
			end
			decode: begin
				case (opcode)
					rType: begin
						stateNext = rExec;
						srcANext  = isShift ? shamt : regA;
						srcBNext  = regB;
						aluOpNext = functOp;
					end
					lw, sw: begin
						stateNext = memAddr;
						srcANext  = regA;
						srcBNext  = signImm;
					end
					addi, slti: begin
						stateNext = iExec;
						srcANext  = regA;
						srcBNext  = signImm;
						aluOpNext = immOp;
					end
					andi, ori, xori: begin
						stateNext = iExec;
						srcANext  = regA;
						srcBNext  = zeroImm;
						aluOpNext = immOp;
					end
					beq: begin
						// Compare rs and rt, PC takes the stored target on zero
						stateNext  = branchExec;
						srcANext   = regA;
						srcBNext   = regB;
						aluOpNext  = subOp;
						branchNext = 1'b1;
						pcSrcNext  = aluOut;
					end
					j: begin
						stateNext   = jumpExec;
						pcWriteNext = 1'b1;
						pcSrcNext   = jumpTarget;
					end
					// Unsupported opcode, back to fetch
					default: stateNext = fetchAddr;
				endcase
			end
			memAddr: begin
				iorDNext = 1'b1;
				if (opcode == lw) begin
					stateNext = memRead;
				end else begin
					stateNext = memStore;
					memWeNext = 1'b1;
				end
			end
			// Read data arrives one cycle after the address
			memRead: stateNext = memWriteback;
			memWriteback: begin
				regWriteNext = 1'b1;
				memToRegNext = 1'b1;
			end
			rExec: begin
				stateNext    = rWriteback;
				regWriteNext = 1'b1;
				regDstNext   = 1'b1;
			end
			iExec: begin
				stateNext    = iWriteback;
				regWriteNext = 1'b1;
			end
			// Remaining states finish the instruction
			default: stateNext = fetchAddr;
		endcase
	end

	//////////////////////////////
	// Registered outputs
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= fetchAddr;
			iorD     <= 1'b0;
			srcA     <= pc;
			srcB     <= four;
			pcSrc    <= aluResult;
			aluOp    <= addOp;
			irWrite  <= 1'b0;
			pcWrite  <= 1'b0;
			branch   <= 1'b0;
			regWrite <= 1'b0;
			regDst   <= 1'b0;
			memToReg <= 1'b0;
			memWe    <= 1'b0;
		end else begin
			state    <= stateNext;
			iorD     <= iorDNext;
			srcA     <= srcANext;
			srcB     <= srcBNext;
			pcSrc    <= pcSrcNext;
			aluOp    <= aluOpNext;
			irWrite  <= irWriteNext;
			pcWrite  <= pcWriteNext;
			branch   <= branchNext;
			regWrite <= regWriteNext;
			regDst   <= regDstNext;
			memToReg <= memToRegNext;
			memWe    <= memWeNext;
		end
	end

endmodule

/* controller/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder
	import mipsPkg::*;
(
	input  aluOpT   aluOp,
	input  functT   funct,
	input  opcodeT  opcode,
	output aluCtrlT aluCtrl
);

	always_comb begin
		case (aluOp)
			// Address and PC arithmetic
			addOp: aluCtrl = aluAdd;
			// beq compare
			subOp: aluCtrl = aluSub;
			functOp: begin
				case (funct)
					functAdd: aluCtrl = aluAdd;
					functSub: aluCtrl = aluSub;
					functAnd: aluCtrl = aluAnd;
					functOr:  aluCtrl = aluOr;
					functXor: aluCtrl = aluXor;
					functSlt: aluCtrl = aluSlt;
					functSll: aluCtrl = aluSll;
					functSrl: aluCtrl = aluSrl;
					functSra: aluCtrl = aluSra;
					default:  aluCtrl = aluAdd;
				endcase
			end
			// Immediate ops decode straight from the opcode
			immOp: begin
				case (opcode)
					andi:    aluCtrl = aluAnd;
					ori:     aluCtrl = aluOr;
					xori:    aluCtrl = aluXor;
					slti:    aluCtrl = aluSlt;
					default: aluCtrl = aluAdd;
				endcase
			end
			default: aluCtrl = aluAdd;
		endcase
	end

endmodule

/* datapath/mipsDatapath.sv */
`timescale 1ns/1ps

module mipsDatapath
	import mipsPkg::*;
#(
	parameter int dataWidth = 32,
	parameter int addrWidth = 10
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 iorD,
	input  srcAT                 srcA,
	input  srcBT                 srcB,
	input  pcSrcT                pcSrc,
	input  logic                 irWrite,
	input  logic                 pcWrite,
	input  logic                 branch,
	input  logic                 regWrite,
	input  logic                 regDst,
	input  logic                 memToReg,
	input  aluCtrlT              aluCtrl,
	input  logic [dataWidth-1:0] memRdata,
	output opcodeT               opcode,
	output functT                funct,
	output logic [addrWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWdata
);

	logic [dataWidth-1:0] pcReg;
	logic [dataWidth-1:0] ir;
	logic [dataWidth-1:0] dataReg;
	logic [dataWidth-1:0] aReg;
	logic [dataWidth-1:0] bReg;
	logic [dataWidth-1:0] aluOutReg;
	logic [dataWidth-1:0] readDataA;
	logic [dataWidth-1:0] readDataB;
	logic [dataWidth-1:0] writeData;
	logic [dataWidth-1:0] immSigned;
	logic [dataWidth-1:0] immZero;
	logic [dataWidth-1:0] shiftAmt;
	logic [dataWidth-1:0] jumpAddr;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluValue;
	logic [dataWidth-1:0] pcNext;
	logic [4:0]           writeAddr;
	logic                 zero;
	logic                 pcEn;

	//////////////////////////////
	// Instruction fields
	//////////////////////////////

	assign opcode    = opcodeT'(ir[31:26]);
	assign funct     = functT'(ir[5:0]);
	assign immSigned = {{(dataWidth-16){ir[15]}}, ir[15:0]};
	assign immZero   = {{(dataWidth-16){1'b0}}, ir[15:0]};
	assign shiftAmt  = {{(dataWidth-5){1'b0}}, ir[10:6]};
	// Upper PC bits kept, 26-bit word index
	assign jumpAddr  = {pcReg[dataWidth-1:28], ir[25:0], 2'b00};

	// rd for R-type, rt for loads and immediates
	assign writeAddr = regDst ? ir[15:11] : ir[20:16];
	assign writeData = memToReg ? dataReg : aluOutReg;

	regFile #(.dataWidth(dataWidth)) regFile_inst (
		.clk      (clk),
		.rst      (rst),
		.readAddrA(ir[25:21]),
		.readAddrB(ir[20:16]),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn  (regWrite),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	//////////////////////////////
	// ALU operands
	//////////////////////////////

	always_comb begin
		case (srcA)
			regA:    opA = aReg;
			shamt:   opA = shiftAmt;
			default: opA = pcReg;
		endcase
		case (srcB)
			regB:    opB = bReg;
			// PC-relative offsets count words
			signImm: opB = (srcA == pc) ? immSigned << 2 : immSigned;
			zeroImm: opB = immZero;
			default: opB = dataWidth'(4);
		endcase
	end

	alu #(.dataWidth(dataWidth)) alu_inst (
		.a      (opA),
		.b      (opB),
		.aluCtrl(aluCtrl),
		.result (aluValue),
		.zero   (zero)
	);

	// Next PC and gated enable
	always_comb begin
		case (pcSrc)
			aluOut:     pcNext = aluOutReg;
			jumpTarget: pcNext = jumpAddr;
			default:    pcNext = aluValue;
		endcase
	end
	assign pcEn = pcWrite | (branch & zero);

	always_ff @(posedge clk) begin
		if (rst) begin
			pcReg <= '0;
		end else if (pcEn) begin
			pcReg <= pcNext;
		end
	end

	// Payload registers, loaded every cycle except IR
	always_ff @(posedge clk) begin
		if (irWrite) begin
			ir <= memRdata;
		end
		dataReg   <= memRdata;
		aReg      <= readDataA;
		bReg      <= readDataB;
		aluOutReg <= aluValue;
	end

	// Byte addresses to word addresses
	assign memAddr  = iorD ? aluOutReg[addrWidth+1:2] : pcReg[addrWidth+1:2];
	assign memWdata = bReg;

endmodule

/* datapath/regFile.sv */
`timescale 1ns/1ps

module regFile #(
	parameter int dataWidth = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [4:0]           readAddrA,
	input  logic [4:0]           readAddrB,
	input  logic [4:0]           writeAddr,
	input  logic [dataWidth-1:0] writeData,
	input  logic                 writeEn,
	output logic [dataWidth-1:0] readDataA,
	output logic [dataWidth-1:0] readDataB
);

	logic [dataWidth-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Register zero hardwired
	assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu
	import mipsPkg::*;
#(
	parameter int dataWidth = 32
) (
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  aluCtrlT              aluCtrl,
	output logic [dataWidth-1:0] result,
	output logic                 zero
);

	logic [4:0] shiftBy;
	logic       lessThan;

	// Shift amount in a, value in b
	assign shiftBy  = a[4:0];
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluCtrl)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluXor:  result = a ^ b;
			aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
			aluSll:  result = b << shiftBy;
			aluSrl:  result = b >> shiftBy;
			// Sign bit fills from the left
			aluSra:  result = $signed(b) >>> shiftBy;
			default: result = a + b;
		endcase
	end

	// Used by beq
	assign zero = (result == '0);

endmodule

/* common/mipsPkg.sv */
package mipsPkg;

	//////////////////////////////
	// Instruction encodings
	//////////////////////////////

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		rType = 6'b000000,
		j     = 6'b000010,
		beq   = 6'b000100,
		addi  = 6'b001000,
		slti  = 6'b001010,
		andi  = 6'b001100,
		ori   = 6'b001101,
		xori  = 6'b001110,
		lw    = 6'b100011,
		sw    = 6'b101011
	} opcodeT;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		functSll = 6'b000000,
		functSrl = 6'b000010,
		functSra = 6'b000011,
		functAdd = 6'b100000,
		functSub = 6'b100010,
		functAnd = 6'b100100,
		functOr  = 6'b100101,
		functXor = 6'b100110,
		functSlt = 6'b101010
	} functT;

	//////////////////////////////
	// Control encodings
	//////////////////////////////

	// Multicycle FSM states
	typedef enum logic [3:0] {
		fetchAddr, fetchLatch, decode,
		memAddr, memRead, memWriteback, memStore,
		rExec, rWriteback, iExec, iWriteback,
		branchExec, jumpExec
	} ctrlStateT;

	// Operation class from the FSM to the ALU decoder
	typedef enum logic [1:0] {addOp, subOp, functOp, immOp} aluOpT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluSlt, aluSll, aluSrl, aluSra
	} aluCtrlT;

	// Operand and next-PC selects
	typedef enum logic [1:0] {pc, regA, shamt} srcAT;
	typedef enum logic [2:0] {regB, four, signImm, zeroImm} srcBT;
	typedef enum logic [1:0] {aluResult, aluOut, jumpTarget} pcSrcT;

endpackage
